/* filelist.f */
hdl/div_pkg.sv
hdl/pe_msb.sv
hdl/div32_nonrestoring_skip.sv
hdl/div_regs_axil.sv
hdl/div_unit_top.sv
testbench/div_tb_clk.sv
testbench/div_tb_checker.sv
testbench/div_tb.sv

/* hdl/div32_nonrestoring_skip.sv */
// operands must stay stable from clear until done; latency is msb index of |dividend| plus four cycles

`timescale 1ns/1ps

module div32_nonrestoring_skip import div_pkg::*; (
    input  logic        CLK,
    input  logic        nRST,

    // control
    input  logic        clear,
    input  logic        is_signed,
    output logic        done,
    input  logic        stall_if_done,

    // operands
    input  logic [31:0] A32_in,
    input  logic [31:0] B32_in,

    // results
    output logic [31:0] quotient_out,
    output logic [31:0] remainder_out
);

    // ----------------------------------------------------------
    // state

    div_fsm_t state, next_state;

    logic a_is_neg;
    logic b_is_neg;
    logic b_is_zero;

    // one extra bit so the magnitude of the most negative value fits
    logic [DIV_W:0] a_abs, next_a_abs;
    logic [DIV_W:0] b_abs;
    logic [DIV_W:0] b_abs_neg;

    logic [DIV_W-1:0]         msb_mask, next_msb_mask;
    logic [$clog2(DIV_W)-1:0] msb_index, next_msb_index;
    logic [$clog2(DIV_W)-1:0] count;

    logic [DIV_W:0]   acc, next_acc;
    logic [DIV_W:0]   acc_fix;
    logic [DIV_W-1:0] quot, next_quot;

    // ----------------------------------------------------------
    // registers

    always_ff @(posedge CLK) begin
        if (!nRST) begin
            state <= DIV_INIT;
            a_is_neg <= 1'b0;
            b_is_neg <= 1'b0;
            b_is_zero <= 1'b0;
            a_abs <= '0;
            b_abs <= '0;
            b_abs_neg <= '0;
            msb_index <= '0;
            msb_mask <= '0;
            count <= '0;
            acc <= '0;
            quot <= '0;
        end else begin
            state <= clear ? DIV_INIT : next_state;

            // operand info tracks the inputs every cycle
            a_is_neg <= is_signed & A32_in[31];
            b_is_neg <= is_signed & B32_in[31];
            b_is_zero <= (B32_in == '0);
            a_abs <= next_a_abs;
            if (is_signed && B32_in[31]) begin
                b_abs <= -{1'b1, B32_in};
                b_abs_neg <= {1'b1, B32_in};
            end else begin
                b_abs <= {1'b0, B32_in};
                b_abs_neg <= -{1'b0, B32_in};
            end

            // skip leading zeros of the dividend
            if (state == DIV_INIT) begin
                msb_index <= next_msb_index;
                msb_mask <= next_msb_mask;
                count <= next_msb_index;
            end else if (state == DIV_ITERS) begin
                count <= count - 1'b1;
            end

            acc <= next_acc;
            quot <= next_quot;
        end
    end

    pe_msb #(
        .WIDTH(DIV_W)
    ) pe_msb_i (
        .req_vec  (next_a_abs[DIV_W-1:0]),
        .ack_mask (next_msb_mask),
        .ack_index(next_msb_index)
    );

    // ----------------------------------------------------------
    // next state and datapath

    always_comb begin
        if (is_signed && A32_in[31]) begin
            next_a_abs = -{1'b1, A32_in};
        end else begin
            next_a_abs = {1'b0, A32_in};
        end

        // add back the divisor if the final remainder went negative
        acc_fix = acc + (b_abs & {(DIV_W + 1){acc[DIV_W]}});

        done = 1'b0;
        next_state = state;
        next_acc = acc;
        next_quot = quot;

        case (state)
            DIV_INIT: begin
                next_state = DIV_ITERS;
                next_acc = '0;
                next_quot = next_a_abs[DIV_W-1:0];
            end

            DIV_ITERS: begin
                if (b_is_zero) begin
                    next_state = DIV_DONE;
                    next_acc = {1'b0, A32_in};
                    next_quot = '1;
                end else if (a_abs < b_abs) begin
                    next_state = DIV_DONE;
                    next_acc = {1'b0, A32_in};
                    next_quot = '0;
                end else begin
                    next_state = (count == '0) ? DIV_CORRECTION : DIV_ITERS;
                    // sign of the partial remainder picks add or subtract
                    if (acc[DIV_W]) begin
                        next_acc = {acc[DIV_W-1:0], quot[msb_index]} + b_abs;
                    end else begin
                        next_acc = {acc[DIV_W-1:0], quot[msb_index]} + b_abs_neg;
                    end
                    // quotient bits shift in under the mask
                    next_quot = {quot[DIV_W-2:0], ~next_acc[DIV_W]} & msb_mask;
                end
            end

            DIV_CORRECTION: begin
                next_state = DIV_DONE;
                next_acc = a_is_neg ? -acc_fix : acc_fix;
                next_quot = (a_is_neg ^ b_is_neg) ? -quot : quot;
            end

            DIV_DONE: begin
                done = 1'b1;
                next_state = stall_if_done ? DIV_DONE : DIV_INIT;
            end

            default: begin
                next_state = DIV_INIT;
            end
        endcase
    end

    assign quotient_out = quot;
    assign remainder_out = acc[DIV_W-1:0];

endmodule

/* hdl/div_pkg.sv */
// register map and state encodings assume 32-bit operands and full-word bus access only

package div_pkg;

    // ----------------------------------------------------------
    // divider FSM

    typedef enum logic [1:0] {
        DIV_INIT,
        DIV_ITERS,
        DIV_CORRECTION,
        DIV_DONE
    } div_fsm_t;

    // ----------------------------------------------------------
    // widths

    localparam int DIV_W       = 32;
    localparam int AXIL_ADDR_W = 5;
    localparam int AXIL_DATA_W = 32;

    // byte addresses of the register map
    localparam logic [AXIL_ADDR_W-1:0] ADDR_A      = 5'h00;
    localparam logic [AXIL_ADDR_W-1:0] ADDR_B      = 5'h04;
    localparam logic [AXIL_ADDR_W-1:0] ADDR_CTRL   = 5'h08;
    localparam logic [AXIL_ADDR_W-1:0] ADDR_QUOT   = 5'h0C;
    localparam logic [AXIL_ADDR_W-1:0] ADDR_REM    = 5'h10;
    localparam logic [AXIL_ADDR_W-1:0] ADDR_STATUS = 5'h14;

    // control and status bit positions
    localparam int CTRL_SIGNED_BIT  = 0;
    localparam int CTRL_START_BIT   = 1;
    localparam int STATUS_BUSY_BIT  = 0;
    localparam int STATUS_VALID_BIT = 1;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

/* hdl/div_regs_axil.sv */
// single outstanding response per channel; only full-word writes accepted and operand writes refused while busy

`timescale 1ns/1ps

module div_regs_axil import div_pkg::*; (
    input  logic                     CLK,
    input  logic                     nRST,

    // AXI4-Lite write channels
    input  logic                     awvalid,
    output logic                     awready,
    input  logic [AXIL_ADDR_W-1:0]   awaddr,
    input  logic                     wvalid,
    output logic                     wready,
    input  logic [AXIL_DATA_W-1:0]   wdata,
    input  logic [AXIL_DATA_W/8-1:0] wstrb,
    output logic                     bvalid,
    input  logic                     bready,
    output logic [1:0]               bresp,

    // AXI4-Lite read channels
    input  logic                     arvalid,
    output logic                     arready,
    input  logic [AXIL_ADDR_W-1:0]   araddr,
    output logic                     rvalid,
    input  logic                     rready,
    output logic [AXIL_DATA_W-1:0]   rdata,
    output logic [1:0]               rresp,

    // divider side
    output logic                     clear,
    output logic                     is_signed,
    output logic [DIV_W-1:0]         A32_in,
    output logic [DIV_W-1:0]         B32_in,
    input  logic                     done,
    input  logic [DIV_W-1:0]         quotient_out,
    input  logic [DIV_W-1:0]         remainder_out
);

    logic live;
    logic wr_accept;
    logic wr_ok;
    logic start_req;
    logic rd_accept;
    logic rd_hit;

    logic [DIV_W-1:0] reg_a;
    logic [DIV_W-1:0] reg_b;
    logic [DIV_W-1:0] reg_quot;
    logic [DIV_W-1:0] reg_rem;
    logic             reg_signed;
    logic             busy;
    logic             valid;

    div_fsm_t               div_view;
    logic [AXIL_DATA_W-1:0] rd_word;

    // ----------------------------------------------------------
    // handshakes

    // address and data taken together
    assign wr_accept = live & awvalid & wvalid & ~bvalid;
    assign awready = wr_accept;
    assign wready = wr_accept;
    assign rd_accept = live & arvalid & ~rvalid;
    assign arready = rd_accept;

    assign wr_ok = ~busy & (&wstrb)
                 & ((awaddr == ADDR_A) | (awaddr == ADDR_B) | (awaddr == ADDR_CTRL));
    assign start_req = wr_accept & wr_ok & (awaddr == ADDR_CTRL) & wdata[CTRL_START_BIT];

    assign clear = start_req;
    assign is_signed = reg_signed;
    assign A32_in = reg_a;
    assign B32_in = reg_b;

    // coarse divider state for the status word
    assign div_view = done ? DIV_DONE : (busy ? DIV_ITERS : DIV_INIT);

    // ----------------------------------------------------------
    // read mux

    always_comb begin
        rd_word = '0;
        rd_hit = 1'b1;
        case (araddr)
            ADDR_A:    rd_word = reg_a;
            ADDR_B:    rd_word = reg_b;
            ADDR_CTRL: rd_word[CTRL_SIGNED_BIT] = reg_signed;
            ADDR_QUOT: rd_word = reg_quot;
            ADDR_REM:  rd_word = reg_rem;
            ADDR_STATUS: begin
                rd_word[STATUS_BUSY_BIT] = busy;
                rd_word[STATUS_VALID_BIT] = valid;
                rd_word[3:2] = div_view;
            end
            default:   rd_hit = 1'b0;
        endcase
    end

    // ----------------------------------------------------------
    // registers

    always_ff @(posedge CLK) begin
        if (!nRST) begin
            live <= 1'b0;
            bvalid <= 1'b0;
            bresp <= RESP_OKAY;
            rvalid <= 1'b0;
            rdata <= '0;
            rresp <= RESP_OKAY;
            reg_a <= '0;
            reg_b <= '0;
            reg_signed <= 1'b0;
            reg_quot <= '0;
            reg_rem <= '0;
            busy <= 1'b0;
            valid <= 1'b0;
        end else begin
            live <= 1'b1;

            // write response held until bready
            if (wr_accept) begin
                bvalid <= 1'b1;
                bresp <= wr_ok ? RESP_OKAY : RESP_SLVERR;
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end

            if (wr_accept && wr_ok) begin
                case (awaddr)
                    ADDR_A:    reg_a <= wdata;
                    ADDR_B:    reg_b <= wdata;
                    ADDR_CTRL: reg_signed <= wdata[CTRL_SIGNED_BIT];
                    default: begin
                    end
                endcase
            end

            // launch and capture never overlap since start needs idle
            if (start_req) begin
                busy <= 1'b1;
                valid <= 1'b0;
            end else if (busy && done) begin
                busy <= 1'b0;
                valid <= 1'b1;
                reg_quot <= quotient_out;
                reg_rem <= remainder_out;
            end

            // read response held until rready
            if (rd_accept) begin
                rvalid <= 1'b1;
                rdata <= rd_word;
                rresp <= rd_hit ? RESP_OKAY : RESP_SLVERR;
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

endmodule

/* hdl/div_unit_top.sv */
// divider result stays parked in DONE until the next start since stall_if_done is tied high

`timescale 1ns/1ps

module div_unit_top import div_pkg::*; (
    input  logic                     CLK,
    input  logic                     nRST,

    // AXI4-Lite slave
    input  logic                     awvalid,
    output logic                     awready,
    input  logic [AXIL_ADDR_W-1:0]   awaddr,
    input  logic                     wvalid,
    output logic                     wready,
    input  logic [AXIL_DATA_W-1:0]   wdata,
    input  logic [AXIL_DATA_W/8-1:0] wstrb,
    output logic                     bvalid,
    input  logic                     bready,
    output logic [1:0]               bresp,
    input  logic                     arvalid,
    output logic                     arready,
    input  logic [AXIL_ADDR_W-1:0]   araddr,
    output logic                     rvalid,
    input  logic                     rready,
    output logic [AXIL_DATA_W-1:0]   rdata,
    output logic [1:0]               rresp
);

    logic             div_clear;
    logic             div_signed;
    logic [DIV_W-1:0] div_a;
    logic [DIV_W-1:0] div_b;
    logic             div_done;
    logic [DIV_W-1:0] div_quot;
    logic [DIV_W-1:0] div_rem;

    div_regs_axil regs_i (
        .CLK          (CLK),
        .nRST         (nRST),
        .awvalid      (awvalid),
        .awready      (awready),
        .awaddr       (awaddr),
        .wvalid       (wvalid),
        .wready       (wready),
        .wdata        (wdata),
        .wstrb        (wstrb),
        .bvalid       (bvalid),
        .bready       (bready),
        .bresp        (bresp),
        .arvalid      (arvalid),
        .arready      (arready),
        .araddr       (araddr),
        .rvalid       (rvalid),
        .rready       (rready),
        .rdata        (rdata),
        .rresp        (rresp),
        .clear        (div_clear),
        .is_signed    (div_signed),
        .A32_in       (div_a),
        .B32_in       (div_b),
        .done         (div_done),
        .quotient_out (div_quot),
        .remainder_out(div_rem)
    );

    // hold done until the register block starts the next division
    div32_nonrestoring_skip div_i (
        .CLK          (CLK),
        .nRST         (nRST),
        .clear        (div_clear),
        .is_signed    (div_signed),
        .done         (div_done),
        .stall_if_done(1'b1),
        .A32_in       (div_a),
        .B32_in       (div_b),
        .quotient_out (div_quot),
        .remainder_out(div_rem)
    );

endmodule

/* hdl/pe_msb.sv */
// purely combinational, so long WIDTH values give a deep carry of the found flag; zero input gives index 0

`timescale 1ns/1ps

module pe_msb #(
    parameter int WIDTH = 32
) (
    input  logic [WIDTH-1:0]         req_vec,
    output logic [WIDTH-1:0]         ack_mask,
    output logic [$clog2(WIDTH)-1:0] ack_index
);

    logic found;

    // ----------------------------------------------------------
    // scan from the top down

    always_comb begin
        found = 1'b0;
        ack_index = '0;
        ack_mask = '0;
        for (int i = WIDTH - 1; i >= 0; i--) begin
            // first set bit seen from the top is the msb
            if (req_vec[i] && !found) begin
                ack_index = ($clog2(WIDTH))'(i);
            end
            found = found | req_vec[i];
            // everything at or below the msb joins the mask
            ack_mask[i] = found;
        end
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# builds and runs the divider testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module div_tb -f filelist.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vdiv_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "NO ERRORS"; then
    exit 0
fi
exit 1

/* testbench/div_cases.txt */
// columns: mode dividend divisor quotient remainder, all hex
// mode bit 0 = signed, bit 1 = write A and B while busy; mode ffffffff ends the list
00000000 00000064 00000007 0000000E 00000002
00000000 FFFFFFFF 00000010 0FFFFFFF 0000000F
00000000 12345678 00001000 00012345 00000678
00000000 FFFFFFF9 00000007 24924923 00000004
00000000 80000000 00000003 2AAAAAAA 00000002
00000000 00000005 00000002 00000002 00000001
00000000 FFFFFFFF FFFFFFFF 00000001 00000000
00000001 00000064 00000007 0000000E 00000002
00000001 FFFFFF9C 00000007 FFFFFFF2 FFFFFFFE
00000001 00000064 FFFFFFF9 FFFFFFF2 00000002
00000001 FFFFFF9C FFFFFFF9 0000000E FFFFFFFE
00000001 FFFFFFF9 00000002 FFFFFFFD FFFFFFFF
00000000 12345678 00000000 FFFFFFFF 12345678
00000001 FFFFFF9C 00000000 FFFFFFFF FFFFFF9C
00000000 00000003 00000007 00000000 00000003
00000001 FFFFFFFD 00000007 00000000 FFFFFFFD
00000001 00000005 FFFFFFF7 00000000 00000005
00000000 00000000 00000005 00000000 00000000
00000001 80000000 FFFFFFFF 80000000 00000000
00000001 80000000 00000002 C0000000 00000000
00000002 FFFFFFFF 00000003 55555555 00000000
00000003 80000001 00000007 EDB6DB6E FFFFFFFF
FFFFFFFF 00000000 00000000 00000000 00000000

/* testbench/div_tb.sv */
// run from the project root so testbench/div_cases.txt is found; holds at most 51 cases

`timescale 1ns/1ps

module div_tb import div_pkg::*; ();

    logic CLK;
    logic nRST;

    // DUT bus
    logic                     awvalid;
    logic                     awready;
    logic [AXIL_ADDR_W-1:0]   awaddr;
    logic                     wvalid;
    logic                     wready;
    logic [AXIL_DATA_W-1:0]   wdata;
    logic [AXIL_DATA_W/8-1:0] wstrb;
    logic                     bvalid;
    logic                     bready = 1'b0;
    logic [1:0]               bresp;
    logic                     arvalid;
    logic                     arready;
    logic [AXIL_ADDR_W-1:0]   araddr;
    logic                     rvalid;
    logic                     rready = 1'b0;
    logic [AXIL_DATA_W-1:0]   rdata;
    logic [1:0]               rresp;

    // expectations handed to the checker
    logic [AXIL_ADDR_W-1:0] exp_waddr;
    logic [1:0]             exp_bresp;
    logic [AXIL_ADDR_W-1:0] exp_raddr;
    logic [AXIL_DATA_W-1:0] exp_rdata;
    logic [AXIL_DATA_W-1:0] exp_rmask;
    logic [1:0]             exp_rresp;
    logic                   case_end;
    int                     case_id;

    int err_count;
    int pass_count;
    int fail_count;
    int b_count;
    int r_count;

    // five words per case, closed by a line with an all-ones mode
    logic [31:0] cases [0:255];
    int          num_cases;
    int          cycle_limit;
    int          cycles;
    int          writes_issued;
    int          reads_issued;
    integer      seed = 15;

    div_tb_clk clk_i (
        .CLK (CLK),
        .nRST(nRST)
    );

    div_unit_top dut_i (
        .CLK    (CLK),
        .nRST   (nRST),
        .awvalid(awvalid),
        .awready(awready),
        .awaddr (awaddr),
        .wvalid (wvalid),
        .wready (wready),
        .wdata  (wdata),
        .wstrb  (wstrb),
        .bvalid (bvalid),
        .bready (bready),
        .bresp  (bresp),
        .arvalid(arvalid),
        .arready(arready),
        .araddr (araddr),
        .rvalid (rvalid),
        .rready (rready),
        .rdata  (rdata),
        .rresp  (rresp)
    );

    div_tb_checker checker_i (
        .CLK       (CLK),
        .nRST      (nRST),
        .awready   (awready),
        .wready    (wready),
        .bvalid    (bvalid),
        .bready    (bready),
        .bresp     (bresp),
        .rvalid    (rvalid),
        .rready    (rready),
        .rdata     (rdata),
        .rresp     (rresp),
        .exp_waddr (exp_waddr),
        .exp_bresp (exp_bresp),
        .exp_raddr (exp_raddr),
        .exp_rdata (exp_rdata),
        .exp_rmask (exp_rmask),
        .exp_rresp (exp_rresp),
        .case_end  (case_end),
        .case_id   (case_id),
        .err_count (err_count),
        .pass_count(pass_count),
        .fail_count(fail_count),
        .b_count   (b_count),
        .r_count   (r_count)
    );

    // ----------------------------------------------------------
    // back-pressure and timeout

    // ready high about three cycles in four
    always @(posedge CLK) begin
        bready <= (($random(seed) & 3) != 0);
        rready <= (($random(seed) & 3) != 0);
    end

    always @(posedge CLK) begin
        cycles++;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // ----------------------------------------------------------
    // bus transactions, each entered just after a rising edge

    task automatic write_reg(input logic [AXIL_ADDR_W-1:0] addr,
                             input logic [AXIL_DATA_W-1:0] data, input logic [1:0] resp);
        exp_waddr <= addr;
        exp_bresp <= resp;
        awvalid <= 1'b1;
        awaddr <= addr;
        wvalid <= 1'b1;
        wdata <= data;
        wstrb <= '1;
        @(posedge CLK);
        while (!awready) @(posedge CLK);
        awvalid <= 1'b0;
        wvalid <= 1'b0;
        @(posedge CLK);
        while (!(bvalid && bready)) @(posedge CLK);
        writes_issued++;
    endtask

    task automatic read_reg(input logic [AXIL_ADDR_W-1:0] addr,
                            input logic [AXIL_DATA_W-1:0] data,
                            input logic [AXIL_DATA_W-1:0] mask,
                            output logic [AXIL_DATA_W-1:0] got);
        exp_raddr <= addr;
        exp_rdata <= data;
        exp_rmask <= mask;
        exp_rresp <= RESP_OKAY;
        arvalid <= 1'b1;
        araddr <= addr;
        @(posedge CLK);
        while (!arready) @(posedge CLK);
        arvalid <= 1'b0;
        @(posedge CLK);
        while (!(rvalid && rready)) @(posedge CLK);
        got = rdata;
        reads_issued++;
    endtask

    // mode bit 0 selects signed, bit 1 pokes A and B while busy
    task automatic run_case(input int idx);
        logic [31:0] mode;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] ctrl;
        logic [31:0] status;
        logic [31:0] status_idle;
        mode = cases[idx * 5];
        a = cases[idx * 5 + 1];
        b = cases[idx * 5 + 2];
        ctrl = '0;
        ctrl[CTRL_START_BIT] = 1'b1;
        ctrl[CTRL_SIGNED_BIT] = mode[0];
        status_idle = '0;
        status_idle[STATUS_VALID_BIT] = 1'b1;
        status_idle[3:2] = DIV_DONE;
        write_reg(ADDR_A, a, RESP_OKAY);
        write_reg(ADDR_B, b, RESP_OKAY);
        write_reg(ADDR_CTRL, ctrl, RESP_OKAY);
        if (mode[1]) begin
            write_reg(ADDR_A, ~a, RESP_SLVERR);
            write_reg(ADDR_B, ~b, RESP_SLVERR);
        end
        // poll until valid with only the reserved upper bits known
        status = '0;
        while (!status[STATUS_VALID_BIT]) begin
            read_reg(ADDR_STATUS, '0, 32'hFFFF_FFF0, status);
        end
        // not busy, result valid, divider parked in DONE
        read_reg(ADDR_STATUS, status_idle, '1, status);
        read_reg(ADDR_QUOT, cases[idx * 5 + 3], '1, status);
        read_reg(ADDR_REM, cases[idx * 5 + 4], '1, status);
        case_id <= idx;
        case_end <= 1'b1;
        @(posedge CLK);
        case_end <= 1'b0;
    endtask

    // ----------------------------------------------------------
    // main sequence

    initial begin
        awvalid = 1'b0;
        awaddr = '0;
        wvalid = 1'b0;
        wdata = '0;
        wstrb = '1;
        arvalid = 1'b0;
        araddr = '0;
        exp_waddr = '0;
        exp_bresp = RESP_OKAY;
        exp_raddr = '0;
        exp_rdata = '0;
        exp_rmask = '0;
        exp_rresp = RESP_OKAY;
        case_end = 1'b0;
        case_id = 0;

        $readmemh("testbench/div_cases.txt", cases);
        num_cases = 0;
        while (num_cases < 51 && cases[num_cases * 5] != 32'hFFFF_FFFF) begin
            num_cases++;
        end
        cycle_limit = num_cases * 80 + 200;

        @(posedge CLK);
        while (!nRST) @(posedge CLK);
        for (int i = 0; i < num_cases; i++) begin
            run_case(i);
        end
        repeat (2) @(posedge CLK);

        if (b_count != writes_issued || r_count != reads_issued) begin
            $display("responses lost or duplicated: %0d of %0d writes, %0d of %0d reads",
                     b_count, writes_issued, r_count, reads_issued);
        end
        $display("totals: %0d cases passed, %0d failed, %0d errors",
                 pass_count, fail_count, err_count);
        if (num_cases > 0 && err_count == 0 && fail_count == 0 && pass_count == num_cases
            && b_count == writes_issued && r_count == reads_issued) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* testbench/div_tb_checker.sv */
// samples only on rising edges; expectations must be set before the handshake they describe

`timescale 1ns/1ps

module div_tb_checker import div_pkg::*; (
    input  logic                   CLK,
    input  logic                   nRST,

    // write acceptance of the DUT
    input  logic                   awready,
    input  logic                   wready,

    // response channels of the DUT
    input  logic                   bvalid,
    input  logic                   bready,
    input  logic [1:0]             bresp,
    input  logic                   rvalid,
    input  logic                   rready,
    input  logic [AXIL_DATA_W-1:0] rdata,
    input  logic [1:0]             rresp,

    // expectations from the testbench top
    input  logic [AXIL_ADDR_W-1:0] exp_waddr,
    input  logic [1:0]             exp_bresp,
    input  logic [AXIL_ADDR_W-1:0] exp_raddr,
    input  logic [AXIL_DATA_W-1:0] exp_rdata,
    input  logic [AXIL_DATA_W-1:0] exp_rmask,
    input  logic [1:0]             exp_rresp,
    input  logic                   case_end,
    input  int                     case_id,

    // totals
    output int                     err_count,
    output int                     pass_count,
    output int                     fail_count,
    output int                     b_count,
    output int                     r_count
);

    int case_errs;

    // response seen last edge but not yet taken
    logic                   b_hold;
    logic [1:0]             b_last;
    logic                   r_hold;
    logic [1:0]             r_last_resp;
    logic [AXIL_DATA_W-1:0] r_last_data;

    function automatic string reg_name(input logic [AXIL_ADDR_W-1:0] addr);
        case (addr)
            ADDR_A:      return "A";
            ADDR_B:      return "B";
            ADDR_CTRL:   return "CTRL";
            ADDR_QUOT:   return "QUOT";
            ADDR_REM:    return "REM";
            ADDR_STATUS: return "STATUS";
            default:     return "unmapped";
        endcase
    endfunction

    task automatic value_fail(input string sig, input logic [31:0] expected,
                              input logic [31:0] got);
        $display("[FAIL] %0t ns %s expected %0h got %0h", $time, sig, expected, got);
        err_count++;
        case_errs++;
    endtask

    task automatic protocol_fail(input string what);
        $display("error at %0t ns: %s", $time, what);
        err_count++;
        case_errs++;
    endtask

    // ----------------------------------------------------------
    // handshake checks

    always @(posedge CLK) begin
        if (!nRST) begin
            err_count = 0;
            pass_count = 0;
            fail_count = 0;
            b_count = 0;
            r_count = 0;
            case_errs = 0;
            b_hold <= 1'b0;
            r_hold <= 1'b0;
        end else begin
            // address and data are only ever taken in the same cycle
            if (awready != wready) begin
                protocol_fail("awready and wready were not raised together");
            end

            // a stalled response must not move
            if (b_hold) begin
                if (!bvalid) begin
                    protocol_fail("bvalid dropped before bready was seen");
                end else if (bresp != b_last) begin
                    value_fail("bresp while stalled", b_last, bresp);
                end
            end
            if (bvalid && bready) begin
                b_count++;
                if (bresp != exp_bresp) begin
                    value_fail($sformatf("bresp %s", reg_name(exp_waddr)), exp_bresp, bresp);
                end
            end
            b_hold <= bvalid & ~bready;
            b_last <= bresp;

            if (r_hold) begin
                if (!rvalid) begin
                    protocol_fail("rvalid dropped before rready was seen");
                end else if (rdata != r_last_data) begin
                    value_fail("rdata while stalled", r_last_data, rdata);
                end else if (rresp != r_last_resp) begin
                    value_fail("rresp while stalled", r_last_resp, rresp);
                end
            end
            if (rvalid && rready) begin
                r_count++;
                // only the masked bits are defined for status polls
                if (((rdata ^ exp_rdata) & exp_rmask) != '0) begin
                    value_fail($sformatf("rdata %s", reg_name(exp_raddr)),
                               exp_rdata & exp_rmask, rdata & exp_rmask);
                end
                if (rresp != exp_rresp) begin
                    value_fail($sformatf("rresp %s", reg_name(exp_raddr)), exp_rresp, rresp);
                end
            end
            r_hold <= rvalid & ~rready;
            r_last_resp <= rresp;
            r_last_data <= rdata;

            if (case_end) begin
                if (case_errs == 0) begin
                    pass_count++;
                    $display("case %0d ok", case_id);
                end else begin
                    fail_count++;
                    $display("case %0d failed with %0d mismatches", case_id, case_errs);
                end
                case_errs = 0;
            end
        end
    end

endmodule

/* testbench/div_tb_clk.sv */
// free-running 20 ns clock from time zero; nRST is released on the second rising edge

`timescale 1ns/1ps

module div_tb_clk (
    output logic CLK,
    output logic nRST
);

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    // reset held low for two rising edges
    initial begin
        nRST = 1'b0;
        repeat (2) @(posedge CLK);
        nRST <= 1'b1;
    end

endmodule
